// File: l1_defs.svh
`ifndef L1_DEFS_SVH
`define L1_DEFS_SVH

// ==================================================
// cpu side widths
// ==================================================
`define L1_ADDR_WID   32
`define L1_DATA_WID   32

// ==================================================
// address split and array depth
// ==================================================
// byte offset within the single-word line
`define L1_OFFSET_WID 2
`define L1_INDEX_WID  4

`define L1_DEPTH      (1 << `L1_INDEX_WID)

// remaining upper address bits
`define L1_TAG_WID    (`L1_ADDR_WID - `L1_INDEX_WID - `L1_OFFSET_WID)

`endif

// File: l1_pkg.sv
`default_nettype none

`include "l1_defs.svh"

package l1_pkg;

    // line coherence state, no shared copies with one core
    typedef enum logic [1:0] {
        INVALID   = 2'b00,
        EXCLUSIVE = 2'b01,
        MODIFIED  = 2'b11
    } line_state_e;

    typedef enum logic [1:0] {
        IDLE      = 2'b00,
        WRITEBACK = 2'b01,
        FILL      = 2'b10,
        DONE      = 2'b11
    } ctrl_state_e;

    // one address word, msb first
    typedef struct packed {
        logic [`L1_TAG_WID-1:0]    tag;
        logic [`L1_INDEX_WID-1:0]  index;
        logic [`L1_OFFSET_WID-1:0] offset;
    } addr_fields_t;

    typedef struct packed {
        line_state_e            state;
        logic [`L1_TAG_WID-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic                    rd;
        logic                    wr;
        logic [`L1_ADDR_WID-1:0] addr;
        logic [`L1_DATA_WID-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                    rd;
        logic                    wr;
        logic [`L1_ADDR_WID-1:0] addr;
        logic [`L1_DATA_WID-1:0] wdata;
    } lv2_req_t;

endpackage

`default_nettype wire

// File: l1_tag_state.sv
`timescale 1ns/1ns
`default_nettype none

`include "l1_defs.svh"

module l1_tag_state (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [`L1_INDEX_WID-1:0]  index,
    input  logic [`L1_TAG_WID-1:0]    tag,
    output logic                      hit,
    output l1_pkg::tag_entry_t        entry,
    input  logic                      upd_en,
    input  l1_pkg::tag_entry_t        upd_entry
);

    // ==================================================
    // tag and state storage
    // ==================================================
    l1_pkg::tag_entry_t entries [`L1_DEPTH];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `L1_DEPTH; i++) begin
                entries[i] <= '{state: l1_pkg::INVALID, tag: '0};
            end
        end else if (upd_en) begin
            entries[index] <= upd_entry;
        end
    end

    // ==================================================
    // lookup
    // ==================================================
    // stored entry also feeds victim selection
    assign entry = entries[index];

    always_comb begin
        hit = 1'b0;
        if (entry.state != l1_pkg::INVALID) begin
            hit = (entry.tag == tag);
        end
    end

endmodule

`default_nettype wire

// File: l1_data_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "l1_defs.svh"

module l1_data_array (
    input  logic                     clk,
    input  logic [`L1_INDEX_WID-1:0] index,
    input  logic                     wr_en,
    input  logic [`L1_DATA_WID-1:0]  wdata,
    output logic [`L1_DATA_WID-1:0]  rdata
);

    // one word per line
    logic [`L1_DATA_WID-1:0] mem [`L1_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[index] <= wdata;
        end
    end

    // async read, same index as the tag lookup
    assign rdata = mem[index];

endmodule

`default_nettype wire

// File: l1_miss_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "l1_defs.svh"

module l1_miss_ctrl (
    input  logic                    clk,
    input  logic                    arst_n,
    input  l1_pkg::cpu_req_t        cpu_req,
    output logic                    cpu_done,
    output logic [`L1_DATA_WID-1:0] cpu_rdata,
    input  logic                    hit,
    input  l1_pkg::tag_entry_t      entry,
    output logic                    upd_en,
    output l1_pkg::tag_entry_t      upd_entry,
    output logic                    data_wr_en,
    output logic [`L1_DATA_WID-1:0] data_wdata,
    input  logic [`L1_DATA_WID-1:0] data_rdata,
    output l1_pkg::lv2_req_t        lv2_req,
    input  logic [`L1_DATA_WID-1:0] lv2_rdata,
    input  logic                    lv2_rd_done,
    input  logic                    lv2_wr_done
);

    l1_pkg::ctrl_state_e  state;
    l1_pkg::addr_fields_t req_f;
    l1_pkg::addr_fields_t fill_addr;
    l1_pkg::addr_fields_t victim_addr;

    logic req_valid;
    logic victim_dirty;
    logic write_hit;
    logic fill_done;

    logic                    lv2_rd;
    logic                    lv2_wr;
    l1_pkg::addr_fields_t    lv2_addr;
    logic [`L1_DATA_WID-1:0] lv2_wdata;

    // ==================================================
    // request decode
    // ==================================================
    assign req_f        = cpu_req.addr;
    assign req_valid    = cpu_req.rd | cpu_req.wr;
    assign victim_dirty = (entry.state == l1_pkg::MODIFIED);

    // line addresses always carry a zero byte offset
    assign fill_addr   = '{tag: req_f.tag, index: req_f.index, offset: '0};
    assign victim_addr = '{tag: entry.tag, index: req_f.index, offset: '0};

    assign write_hit = (state == l1_pkg::IDLE) && cpu_req.wr && hit;
    assign fill_done = (state == l1_pkg::FILL) && lv2_rd_done;

    // ==================================================
    // array update
    // ==================================================
    // fill installs a clean line, cpu write dirties it
    assign data_wr_en = write_hit | fill_done;
    assign upd_en     = write_hit | fill_done;
    assign data_wdata = fill_done ? lv2_rdata : cpu_req.wdata;

    always_comb begin
        upd_entry.tag   = req_f.tag;
        upd_entry.state = fill_done ? l1_pkg::EXCLUSIVE : l1_pkg::MODIFIED;
    end

    // ==================================================
    // sequencing
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= l1_pkg::IDLE;
            cpu_done <= 1'b0;
            lv2_rd   <= 1'b0;
            lv2_wr   <= 1'b0;
        end else begin
            cpu_done <= 1'b0;
            case (state)
                l1_pkg::IDLE: begin
                    if (req_valid) begin
                        if (hit) begin
                            cpu_done <= 1'b1;
                            state    <= l1_pkg::DONE;
                        end else if (victim_dirty) begin
                            lv2_wr <= 1'b1;
                            state  <= l1_pkg::WRITEBACK;
                        end else begin
                            lv2_rd <= 1'b1;
                            state  <= l1_pkg::FILL;
                        end
                    end
                end
                l1_pkg::WRITEBACK: begin
                    if (lv2_wr_done) begin
                        lv2_wr <= 1'b0;
                        lv2_rd <= 1'b1;
                        state  <= l1_pkg::FILL;
                    end
                end
                l1_pkg::FILL: begin
                    // back to idle, the retry then hits
                    if (lv2_rd_done) begin
                        lv2_rd <= 1'b0;
                        state  <= l1_pkg::IDLE;
                    end
                end
                l1_pkg::DONE: begin
                    // request still high here, skip it
                    state <= l1_pkg::IDLE;
                end
                default: begin
                    state <= l1_pkg::IDLE;
                end
            endcase
        end
    end

    // ==================================================
    // payload registers
    // ==================================================
    always_ff @(posedge clk) begin
        if (state == l1_pkg::IDLE && req_valid) begin
            if (hit && cpu_req.rd) begin
                cpu_rdata <= data_rdata;
            end
            if (!hit && victim_dirty) begin
                lv2_addr  <= victim_addr;
                lv2_wdata <= data_rdata;
            end else begin
                lv2_addr <= fill_addr;
            end
        end else if (state == l1_pkg::WRITEBACK && lv2_wr_done) begin
            lv2_addr <= fill_addr;
        end
    end

    assign lv2_req = '{rd: lv2_rd, wr: lv2_wr, addr: lv2_addr, wdata: lv2_wdata};

endmodule

`default_nettype wire

// File: l1_dcache.sv
`timescale 1ns/1ns
`default_nettype none

`include "l1_defs.svh"

module l1_dcache (
    input  logic                    clk,
    input  logic                    arst_n,
    input  l1_pkg::cpu_req_t        cpu_req,
    output logic                    cpu_done,
    output logic [`L1_DATA_WID-1:0] cpu_rdata,
    output l1_pkg::lv2_req_t        lv2_req,
    input  logic [`L1_DATA_WID-1:0] lv2_rdata,
    input  logic                    lv2_rd_done,
    input  logic                    lv2_wr_done
);

    l1_pkg::addr_fields_t    req_f;
    logic                    hit;
    l1_pkg::tag_entry_t      entry;
    logic                    upd_en;
    l1_pkg::tag_entry_t      upd_entry;
    logic                    data_wr_en;
    logic [`L1_DATA_WID-1:0] data_wdata;
    logic [`L1_DATA_WID-1:0] data_rdata;

    assign req_f = cpu_req.addr;

    l1_tag_state tag_state_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .index     (req_f.index),
        .tag       (req_f.tag),
        .hit       (hit),
        .entry     (entry),
        .upd_en    (upd_en),
        .upd_entry (upd_entry)
    );

    l1_data_array data_array_i (
        .clk   (clk),
        .index (req_f.index),
        .wr_en (data_wr_en),
        .wdata (data_wdata),
        .rdata (data_rdata)
    );

    l1_miss_ctrl miss_ctrl_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .cpu_req     (cpu_req),
        .cpu_done    (cpu_done),
        .cpu_rdata   (cpu_rdata),
        .hit         (hit),
        .entry       (entry),
        .upd_en      (upd_en),
        .upd_entry   (upd_entry),
        .data_wr_en  (data_wr_en),
        .data_wdata  (data_wdata),
        .data_rdata  (data_rdata),
        .lv2_req     (lv2_req),
        .lv2_rdata   (lv2_rdata),
        .lv2_rd_done (lv2_rd_done),
        .lv2_wr_done (lv2_wr_done)
    );

endmodule

`default_nettype wire

// File: tb_l1_dcache.sv
`timescale 1ns/1ns
`default_nettype none

`include "l1_defs.svh"

module tb_l1_dcache;

    localparam int CLK_PERIOD   = 4;
    localparam int NUM_REQUESTS = 10;
    // writeback plus fill at the longest level 2 delay, then the hit
    localparam int WORST_MISS_CYCLES = 24;
    localparam int REQ_LIMIT         = WORST_MISS_CYCLES;

    localparam logic [31:0] ADDR_A = 32'h0000_100E;
    localparam logic [31:0] LINE_A = 32'h0000_100C;
    localparam logic [31:0] ADDR_B = 32'h0000_200D;
    localparam logic [31:0] LINE_B = 32'h0000_200C;
    localparam logic [31:0] LINE_C = 32'h0000_300C;
    localparam logic [31:0] ADDR_D = 32'h0000_4025;
    localparam logic [31:0] LINE_D = 32'h0000_4024;
    localparam logic [31:0] LINE_E = 32'h0000_5024;

    logic                    clk;
    logic                    arst_n;
    l1_pkg::cpu_req_t        cpu_req;
    logic                    cpu_done;
    logic [`L1_DATA_WID-1:0] cpu_rdata;
    l1_pkg::lv2_req_t        lv2_req;
    logic [`L1_DATA_WID-1:0] lv2_rdata;
    logic                    lv2_rd_done;
    logic                    lv2_wr_done;

    logic [31:0] l2_mem [logic [31:0]];
    logic        log_wr [$];
    logic [31:0] log_addr [$];
    logic [31:0] log_data [$];
    logic [15:0] lfsr_state = 16'd16;

    string cur_test;
    int    error_count = 0;
    int    errors_at_start;
    int    tests_run = 0;
    int    tests_failed = 0;

    l1_dcache dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .cpu_req     (cpu_req),
        .cpu_done    (cpu_done),
        .cpu_rdata   (cpu_rdata),
        .lv2_req     (lv2_req),
        .lv2_rdata   (lv2_rdata),
        .lv2_rd_done (lv2_rd_done),
        .lv2_wr_done (lv2_wr_done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==================================================
    // helpers
    // ==================================================
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = (value << 1) | lfsr_state[0];
        end
    endtask

    // contents of level 2 words never written
    function automatic logic [31:0] l2_fill_word(input logic [31:0] addr);
        return {addr[15:0], ~addr[31:16]} ^ 32'h5A5A_C3C3;
    endfunction

    function automatic logic [31:0] l2_read(input logic [31:0] addr);
        return l2_mem.exists(addr) ? l2_mem[addr] : l2_fill_word(addr);
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_count(input int exp);
        check_value("lv2 transaction count", exp, log_addr.size());
    endtask

    task automatic check_lv2(input int idx, input logic exp_wr, input logic [31:0] exp_addr,
                             input logic [31:0] exp_data);
        if (idx < log_addr.size()) begin
            assert (log_wr[idx] == exp_wr) else begin
                $display("%s: lv2 transaction %0d was a %s where a %s was expected", cur_test,
                         idx, log_wr[idx] ? "write" : "read", exp_wr ? "write" : "read");
                error_count++;
            end
            check_value("lv2 addr", exp_addr, log_addr[idx]);
            check_value("lv2 data", exp_data, log_data[idx]);
        end
    endtask

    task automatic cpu_access(input logic is_wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        @(posedge clk);
        cpu_req <= '{rd: !is_wr, wr: is_wr, addr: addr, wdata: wdata};
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!cpu_done && cycles < REQ_LIMIT);
        assert (cpu_done) else begin
            $display("%s: cpu_done did not arrive within %0d cycles", cur_test, REQ_LIMIT);
            error_count++;
        end
        rdata = cpu_rdata;
        @(posedge clk);
        cpu_req <= '0;
    endtask

    task automatic start_test(input string name);
        cur_test        = name;
        errors_at_start = error_count;
        log_wr.delete();
        log_addr.delete();
        log_data.delete();
    endtask

    task automatic finish_test();
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("%s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", cur_test, error_count - errors_at_start);
        end
    endtask

    // ==================================================
    // directed tests
    // ==================================================
    task automatic test_read_miss();
        logic [31:0] rdata;
        start_test("read_miss");
        cpu_access(1'b0, ADDR_A, '0, rdata);
        check_value("read data", l2_fill_word(LINE_A), rdata);
        check_count(1);
        check_lv2(0, 1'b0, LINE_A, l2_fill_word(LINE_A));
        finish_test();
    endtask

    task automatic test_read_hit();
        logic [31:0] rdata;
        start_test("read_hit");
        cpu_access(1'b0, ADDR_A, '0, rdata);
        check_value("read data", l2_fill_word(LINE_A), rdata);
        check_count(0);
        finish_test();
    endtask

    task automatic test_write_hit();
        logic [31:0] rdata;
        start_test("write_hit");
        cpu_access(1'b1, ADDR_A, 32'hDEAD_BEEF, rdata);
        cpu_access(1'b0, ADDR_A, '0, rdata);
        check_value("read data", 32'hDEAD_BEEF, rdata);
        check_count(0);
        finish_test();
    endtask

    task automatic test_modified_eviction();
        logic [31:0] rdata;
        start_test("modified_eviction");
        cpu_access(1'b0, ADDR_B, '0, rdata);
        check_value("read data", l2_fill_word(LINE_B), rdata);
        check_count(2);
        check_lv2(0, 1'b1, LINE_A, 32'hDEAD_BEEF);
        check_lv2(1, 1'b0, LINE_B, l2_fill_word(LINE_B));
        finish_test();
    endtask

    task automatic test_clean_eviction();
        logic [31:0] rdata;
        start_test("clean_eviction");
        cpu_access(1'b0, LINE_C, '0, rdata);
        check_value("read data", l2_fill_word(LINE_C), rdata);
        check_count(1);
        check_lv2(0, 1'b0, LINE_C, l2_fill_word(LINE_C));
        finish_test();
        // written back word must come back from level 2
        start_test("clean_eviction_refetch");
        cpu_access(1'b0, ADDR_A, '0, rdata);
        check_value("read data", 32'hDEAD_BEEF, rdata);
        check_count(1);
        check_lv2(0, 1'b0, LINE_A, 32'hDEAD_BEEF);
        finish_test();
    endtask

    task automatic test_write_miss();
        logic [31:0] rdata;
        start_test("write_miss");
        cpu_access(1'b1, ADDR_D, 32'h1234_5678, rdata);
        check_count(1);
        check_lv2(0, 1'b0, LINE_D, l2_fill_word(LINE_D));
        cpu_access(1'b0, ADDR_D, '0, rdata);
        check_value("read data", 32'h1234_5678, rdata);
        check_count(1);
        cpu_access(1'b0, LINE_E, '0, rdata);
        check_value("evict read data", l2_fill_word(LINE_E), rdata);
        check_count(3);
        check_lv2(1, 1'b1, LINE_D, 32'h1234_5678);
        check_lv2(2, 1'b0, LINE_E, l2_fill_word(LINE_E));
        finish_test();
    endtask

    // ==================================================
    // level 2 model
    // ==================================================
    initial begin : l2_model
        logic [31:0] addr;
        logic        is_rd;
        int          delay;
        forever begin
            @(negedge clk);
            if (arst_n) begin
                assert (!(lv2_req.rd && lv2_req.wr)) else begin
                    $display("%s: level 2 read and write requested together", cur_test);
                    error_count++;
                end
            end
            if (arst_n && (lv2_req.rd || lv2_req.wr)) begin
                addr  = lv2_req.addr;
                is_rd = lv2_req.rd;
                draw_bits(2, delay);
                delay = delay + 1;
                log_wr.push_back(!is_rd);
                log_addr.push_back(addr);
                if (is_rd) begin
                    log_data.push_back(l2_read(addr));
                end else begin
                    log_data.push_back(lv2_req.wdata);
                    l2_mem[addr] = lv2_req.wdata;
                end
                repeat (delay) @(posedge clk);
                lv2_rdata   <= is_rd ? l2_read(addr) : '0;
                lv2_rd_done <= is_rd;
                lv2_wr_done <= !is_rd;
                @(posedge clk);
                lv2_rd_done <= 1'b0;
                lv2_wr_done <= 1'b0;
            end
        end
    end

    initial begin
        #(NUM_REQUESTS * WORST_MISS_CYCLES * CLK_PERIOD + 50 * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        cpu_req     = '0;
        lv2_rdata   = '0;
        lv2_rd_done = 1'b0;
        lv2_wr_done = 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        test_read_miss();
        test_read_hit();
        test_write_hit();
        test_modified_eviction();
        test_clean_eviction();
        test_write_miss();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
l1_pkg.sv
l1_tag_state.sv
l1_data_array.sv
l1_miss_ctrl.sv
l1_dcache.sv
tb_l1_dcache.sv
